// File: all.f
+incdir+dv
design/pio_bus_pkg.sv
design/pio_time_pkg.sv
design/sfifo1f.sv
design/pio_bus.sv
design/pio_reg_dev.sv
design/pio_subsys.sv
dv/pio_subsys_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module pio_subsys_tb -f all.f -Mdir obj_dir \
        > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vpio_subsys_tb > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || echo "PASS"
exit 0

// File: dv/pio_tb_tasks.svh
task automatic report_failure(input string msg);
        failed = 1'b1;
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
endtask

task automatic check_word(input string name, input pio_bus_pkg::pio_word_t expected,
                          input pio_bus_pkg::pio_word_t actual);
        if (actual !== expected) begin
                report_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
endtask

task automatic check_time(input string name, input pio_time_pkg::real_time_t expected,
                          input pio_time_pkg::real_time_t actual);
        if (actual !== expected) begin
                report_failure($sformatf("ERR %s expected %0d actual %0d", name, expected,
                                         actual));
        end
endtask

// a write queued behind a read keeps its aw and w fifos full
task automatic verify_write_parked(input string name, input logic wr_held);
        if (wr_held && (awready || wready)) begin
                report_failure($sformatf("%s: write ready rose while the write was queued",
                                         name));
        end
endtask

// offers aw/w and/or ar together, drops each valid once its beat went through
task automatic send_request(input logic do_wr, input logic do_rd,
                            input pio_bus_pkg::pio_word_t addr,
                            input pio_bus_pkg::pio_word_t data);
        logic aw_done;
        logic w_done;
        logic ar_done;
        awaddr  = addr;
        wdata   = data;
        araddr  = addr;
        awvalid = do_wr;
        wvalid  = do_wr;
        arvalid = do_rd;
        while (awvalid || wvalid || arvalid) begin
                aw_done = awvalid && awready;
                w_done  = wvalid && wready;
                ar_done = arvalid && arready;
                @(posedge clk);
                #1;
                if (aw_done) awvalid = 1'b0;
                if (w_done) wvalid = 1'b0;
                if (ar_done) arvalid = 1'b0;
        end
endtask

// waits for b or r, holds ready low for the stall, then takes the beat
task automatic take_response(input string name, input logic is_read, input int stall,
                             input pio_bus_pkg::pio_word_t expected, input logic wr_held);
        pio_bus_pkg::pio_word_t held;
        while (!(is_read ? rvalid : bvalid)) begin
                verify_write_parked(name, wr_held);
                @(posedge clk);
                #1;
        end
        held = rdata;
        repeat (stall) begin
                @(posedge clk);
                #1;
                if (!(is_read ? rvalid : bvalid)) begin
                        report_failure($sformatf("%s: response valid dropped during the stall",
                                                 name));
                end
                if (is_read) check_word(name, held, rdata);   // data frozen while stalled
                verify_write_parked(name, wr_held);
        end
        if (is_read) check_word(name, expected, rdata);
        rready = is_read;
        bready = !is_read;
        @(posedge clk);
        #1;
        rready = 1'b0;
        bready = 1'b0;
endtask

// File: dv/pio_subsys_tb.sv
`timescale 1ns/10ps

module pio_subsys_tb;

        typedef enum {
                OP_WR,
                OP_RD,
                OP_BOTH                        // read and write offered on the same cycle
        } op_t;

        typedef struct {
                string                  name;
                op_t                    op;
                pio_bus_pkg::pio_word_t addr;
                pio_bus_pkg::pio_word_t wdata;
                pio_bus_pkg::pio_word_t expected;
                int                     stall;
        } entry_t;

        localparam int NUM_REGS = pio_bus_pkg::NUM_OF_PIO * (2 ** pio_bus_pkg::REG_IDX_NBITS);

        logic                     clk;
        logic                     rst_n;
        pio_bus_pkg::pio_word_t   awaddr;
        logic                     awvalid;
        logic                     awready;
        pio_bus_pkg::pio_word_t   wdata;
        logic                     wvalid;
        logic                     wready;
        logic                     bvalid;
        logic                     bready;
        pio_bus_pkg::pio_word_t   araddr;
        logic                     arvalid;
        logic                     arready;
        pio_bus_pkg::pio_word_t   rdata;
        logic                     rvalid;
        logic                     rready;
        pio_time_pkg::real_time_t current_time;

        entry_t                 tests [$];
        pio_bus_pkg::pio_word_t mirror [NUM_REGS];     // register contents as the tb expects
        logic                   failed      = 1'b0;
        int                     cycle_count = 0;
        int                     cycle_limit = 0;
        int unsigned            live_cycles = 0;       // edges seen with rst_n high

        `include "pio_tb_tasks.svh"

        pio_subsys pio_subsys_inst (
                .clk          (clk),
                .rst_n        (rst_n),
                .awaddr       (awaddr),
                .awvalid      (awvalid),
                .awready      (awready),
                .wdata        (wdata),
                .wvalid       (wvalid),
                .wready       (wready),
                .bvalid       (bvalid),
                .bready       (bready),
                .araddr       (araddr),
                .arvalid      (arvalid),
                .arready      (arready),
                .rdata        (rdata),
                .rvalid       (rvalid),
                .rready       (rready),
                .current_time (current_time)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (rst_n) live_cycles <= live_cycles + 1;
                if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                        report_failure($sformatf("timed out waiting for the DUT after %0d cycles",
                                                 cycle_count));
                end
        end

        // flat index from the device bit and the register index
        function automatic int mirror_index(input pio_bus_pkg::pio_word_t addr);
                return int'(addr[pio_bus_pkg::DEV_SEL_BIT]) * (2 ** pio_bus_pkg::REG_IDX_NBITS) +
                       int'(addr[pio_bus_pkg::REG_IDX_NBITS-1:0]);
        endfunction

        task automatic add_entry(input string name, input op_t op,
                                 input pio_bus_pkg::pio_word_t addr,
                                 input pio_bus_pkg::pio_word_t wdata);
                entry_t e;
                e.name     = name;
                e.op       = op;
                e.addr     = addr;
                e.wdata    = wdata;
                e.expected = (op == OP_WR) ? wdata : mirror[mirror_index(addr)];
                e.stall    = int'($urandom % 8);
                if (op != OP_RD) mirror[mirror_index(addr)] = wdata;
                tests.push_back(e);
        endtask

        task automatic build_tests();
                int i;
                add_entry("unwritten_dev0", OP_RD, 16'h0001, '0);
                add_entry("unwritten_dev1", OP_RD, 16'h0006, '0);
                add_entry("wr_dev0", OP_WR, 16'h0000, 16'ha5a5);
                add_entry("rd_dev0", OP_RD, 16'h0000, '0);
                add_entry("wr_dev1", OP_WR, 16'h0007, 16'h3c3c);
                add_entry("rd_dev1", OP_RD, 16'h0007, '0);
                for (i = 0; i < NUM_REGS; i++) begin     // junk in the upper address bits
                        add_entry($sformatf("fill_%0d", i), OP_WR,
                                  16'(i) | 16'(16'h0400 * (i + 1)), 16'(16'h1000 + i * 16'h0111));
                end
                for (i = 0; i < NUM_REGS; i++) begin
                        add_entry($sformatf("readback_%0d", i), OP_RD,
                                  16'(i) | 16'(16'h0008 * i) | 16'h8000, '0);
                end
                add_entry("prio_dev0", OP_BOTH, 16'h0002, 16'hbeef);
                add_entry("prio_dev0_new", OP_RD, 16'h0002, '0);
                add_entry("prio_dev1", OP_BOTH, 16'h0105, 16'hcafe);
                add_entry("prio_dev1_new", OP_RD, 16'h0005, '0);
        endtask

        task automatic run_entry(input entry_t e);
                case (e.op)
                OP_WR: begin
                        send_request(1'b1, 1'b0, e.addr, e.wdata);
                        take_response(e.name, 1'b0, e.stall, '0, 1'b0);
                end
                OP_RD: begin
                        send_request(1'b0, 1'b1, e.addr, e.wdata);
                        take_response(e.name, 1'b1, e.stall, e.expected, 1'b0);
                end
                default: begin
                        send_request(1'b1, 1'b1, e.addr, e.wdata);
                        take_response(e.name, 1'b1, e.stall, e.expected, 1'b1);  // write waits behind
                        take_response(e.name, 1'b0, e.stall, '0, 1'b0);
                end
                endcase
                check_time(e.name, pio_time_pkg::real_time_t'(live_cycles >>
                           pio_time_pkg::TIME_BASE_NBITS), current_time);
        endtask

        initial begin
                void'($urandom(32'h8f88));
                rst_n   = 1'b0;
                awaddr  = '0;
                awvalid = 1'b0;
                wdata   = '0;
                wvalid  = 1'b0;
                bready  = 1'b0;
                araddr  = '0;
                arvalid = 1'b0;
                rready  = 1'b0;
                for (int i = 0; i < NUM_REGS; i++) begin
                        mirror[i] = '0;
                end
                build_tests();
                cycle_limit = tests.size() * 60 + 200;
                repeat (3) @(posedge clk);
                #1;
                rst_n = 1'b1;
                foreach (tests[i]) begin
                        run_entry(tests[i]);
                end
                if (!failed) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

// File: design/pio_subsys.sv
`timescale 1ns/10ps

module pio_subsys (
        input  logic                     clk,
        input  logic                     rst_n,
        input  pio_bus_pkg::pio_word_t   awaddr,
        input  logic                     awvalid,
        output logic                     awready,
        input  pio_bus_pkg::pio_word_t   wdata,
        input  logic                     wvalid,
        output logic                     wready,
        output logic                     bvalid,
        input  logic                     bready,
        input  pio_bus_pkg::pio_word_t   araddr,
        input  logic                     arvalid,
        output logic                     arready,
        output pio_bus_pkg::pio_word_t   rdata,
        output logic                     rvalid,
        input  logic                     rready,
        output pio_time_pkg::real_time_t current_time
);

        logic                    pio_start;
        logic                    pio_rw;
        pio_bus_pkg::pio_word_t  pio_addr_wdata;
        pio_bus_pkg::pio_mask_t  clk_div;
        pio_bus_pkg::pio_mask_t  pio_ack;
        pio_bus_pkg::pio_mask_t  pio_rvalid;
        pio_bus_pkg::pio_word_t  pio_rdata [pio_bus_pkg::NUM_OF_PIO];

        pio_bus u_pio_bus (
                .clk            (clk),
                .rst_n          (rst_n),
                .awaddr         (awaddr),
                .awvalid        (awvalid),
                .awready        (awready),
                .wdata          (wdata),
                .wvalid         (wvalid),
                .wready         (wready),
                .bvalid         (bvalid),
                .bready         (bready),
                .araddr         (araddr),
                .arvalid        (arvalid),
                .arready        (arready),
                .rdata          (rdata),
                .rvalid         (rvalid),
                .rready         (rready),
                .clk_div        (clk_div),
                .pio_ack        (pio_ack),
                .pio_rvalid     (pio_rvalid),
                .pio_rdata      (pio_rdata),
                .pio_start      (pio_start),
                .pio_rw         (pio_rw),
                .pio_addr_wdata (pio_addr_wdata),
                .current_time   (current_time)
        );

        pio_reg_dev #(.DEV_ID(1'b0), .DIV(2)) u_pio_dev0 (
                .clk            (clk),
                .rst_n          (rst_n),
                .pio_start      (pio_start),
                .pio_rw         (pio_rw),
                .pio_addr_wdata (pio_addr_wdata),
                .clk_div        (clk_div[0]),
                .pio_ack        (pio_ack[0]),
                .pio_rvalid     (pio_rvalid[0]),
                .pio_rdata      (pio_rdata[0])
        );

        pio_reg_dev #(.DEV_ID(1'b1), .DIV(3)) u_pio_dev1 (
                .clk            (clk),
                .rst_n          (rst_n),
                .pio_start      (pio_start),
                .pio_rw         (pio_rw),
                .pio_addr_wdata (pio_addr_wdata),
                .clk_div        (clk_div[1]),
                .pio_ack        (pio_ack[1]),
                .pio_rvalid     (pio_rvalid[1]),
                .pio_rdata      (pio_rdata[1])
        );

endmodule

// File: design/pio_reg_dev.sv
`timescale 1ns/10ps

module pio_reg_dev #(
        parameter bit DEV_ID = 1'b0,
        parameter int DIV    = 2
) (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   pio_start,
        input  logic                   pio_rw,
        input  pio_bus_pkg::pio_word_t pio_addr_wdata,
        output logic                   clk_div,
        output logic                   pio_ack,
        output logic                   pio_rvalid,
        output pio_bus_pkg::pio_word_t pio_rdata
);

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_WDATA,
                ST_WAIT,
                ST_RESP
        } state_t;

        state_t                  state;
        logic [$clog2(DIV)-1:0]  div_cnt;
        logic                    data_next;    // next start carries write data
        logic                    addr_hit;
        logic                    is_write;
        logic [pio_bus_pkg::REG_IDX_NBITS-1:0] reg_idx;
        pio_bus_pkg::pio_word_t  wr_word;
        pio_bus_pkg::pio_word_t  regs [2**pio_bus_pkg::REG_IDX_NBITS];

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        div_cnt <= '0;
                end else if (clk_div) begin
                        div_cnt <= '0;
                end else begin
                        div_cnt <= div_cnt + 1'b1;
                end
        end

        assign clk_div = (div_cnt == DIV - 1);

        // any write address start, ours or not, is followed by a data word
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        data_next <= 1'b0;
                end else begin
                        data_next <= pio_start && pio_rw && !data_next;
                end
        end

        assign addr_hit = pio_start && !data_next &&
                          (pio_addr_wdata[pio_bus_pkg::DEV_SEL_BIT] == DEV_ID);

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state      <= ST_IDLE;
                        pio_ack    <= 1'b0;
                        pio_rvalid <= 1'b0;
                        for (int i = 0; i < 2**pio_bus_pkg::REG_IDX_NBITS; i++) begin
                                regs[i] <= '0;
                        end
                end else begin
                        case (state)
                        ST_IDLE: begin
                                if (addr_hit) begin
                                        state <= pio_rw ? ST_WDATA : ST_WAIT;
                                end
                        end
                        ST_WDATA: begin
                                if (pio_start) begin
                                        state <= ST_WAIT;
                                end
                        end
                        ST_WAIT: begin
                                if (clk_div) begin
                                        if (is_write) begin
                                                regs[reg_idx] <= wr_word;
                                                pio_ack       <= 1'b1;
                                        end else begin
                                                pio_rvalid <= 1'b1;
                                        end
                                        state <= ST_RESP;
                                end
                        end
                        default: begin
                                if (clk_div) begin     // flag held one tick period
                                        pio_ack    <= 1'b0;
                                        pio_rvalid <= 1'b0;
                                        state      <= ST_IDLE;
                                end
                        end
                        endcase
                end
        end

        // access captured from the address and data starts
        always_ff @(posedge clk) begin
                if (state == ST_IDLE && addr_hit) begin
                        is_write <= pio_rw;
                        reg_idx  <= pio_addr_wdata[pio_bus_pkg::REG_IDX_NBITS-1:0];
                end
                if (state == ST_WDATA && pio_start) begin
                        wr_word <= pio_addr_wdata;
                end
                if (state == ST_WAIT && clk_div && !is_write) begin
                        pio_rdata <= regs[reg_idx];
                end
        end

endmodule

// File: design/pio_bus.sv
`timescale 1ns/10ps

module pio_bus (
        input  logic                     clk,
        input  logic                     rst_n,

        input  pio_bus_pkg::pio_word_t   awaddr,
        input  logic                     awvalid,
        output logic                     awready,
        input  pio_bus_pkg::pio_word_t   wdata,
        input  logic                     wvalid,
        output logic                     wready,
        output logic                     bvalid,
        input  logic                     bready,
        input  pio_bus_pkg::pio_word_t   araddr,
        input  logic                     arvalid,
        output logic                     arready,
        output pio_bus_pkg::pio_word_t   rdata,
        output logic                     rvalid,
        input  logic                     rready,

        input  pio_bus_pkg::pio_mask_t   clk_div,
        input  pio_bus_pkg::pio_mask_t   pio_ack,
        input  pio_bus_pkg::pio_mask_t   pio_rvalid,
        input  pio_bus_pkg::pio_word_t   pio_rdata [pio_bus_pkg::NUM_OF_PIO],

        output logic                     pio_start,
        output logic                     pio_rw,
        output pio_bus_pkg::pio_word_t   pio_addr_wdata,

        output pio_time_pkg::real_time_t current_time
);

        logic [pio_time_pkg::TIME_BASE_NBITS-1:0] time_base;

        logic                   waddr_empty;
        logic                   wdata_empty;
        logic                   raddr_empty;
        logic                   rdata_empty;
        logic                   wresp_empty;
        logic                   waddr_full;
        logic                   wdata_full;
        logic                   raddr_full;
        pio_bus_pkg::pio_word_t waddr_dout;
        pio_bus_pkg::pio_word_t wdata_dout;
        pio_bus_pkg::pio_word_t raddr_dout;

        logic busy;                            // one pio transaction in flight
        logic data_pend;                       // write data word goes out next cycle
        logic rd_start;
        logic wr_start;
        logic rdata_pop;
        logic wresp_pop;

        logic [$clog2(pio_bus_pkg::NUM_OF_PIO)-1:0] sel_ack;
        logic [$clog2(pio_bus_pkg::NUM_OF_PIO)-1:0] sel_rd;

        logic                   latch_ack;
        logic                   latch_ack_d1;
        logic                   latch_rvalid;
        logic                   latch_rvalid_d1;
        pio_bus_pkg::pio_word_t latch_rdata;
        logic                   rdata_push;
        logic                   wresp_push;

        // reads win over writes
        assign rd_start = !busy && !raddr_empty;
        assign wr_start = !busy && raddr_empty && !waddr_empty && !wdata_empty;

        assign rdata_pop = rvalid && rready;
        assign wresp_pop = bvalid && bready;

        assign awready = !waddr_full;
        assign wready  = !wdata_full;
        assign arready = !raddr_full;
        assign rvalid  = !rdata_empty;
        assign bvalid  = !wresp_empty;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        busy      <= 1'b0;
                        data_pend <= 1'b0;
                        pio_start <= 1'b0;
                        pio_rw    <= 1'b0;
                end else begin
                        pio_start <= rd_start || wr_start || data_pend;
                        data_pend <= wr_start;
                        if (rd_start || wr_start) begin
                                busy   <= 1'b1;
                                pio_rw <= wr_start;
                        end else if (rdata_pop || wresp_pop) begin
                                busy <= 1'b0;  // response taken by the master
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rd_start) begin
                        pio_addr_wdata <= raddr_dout;
                end else if (wr_start) begin
                        pio_addr_wdata <= waddr_dout;
                end else if (data_pend) begin
                        pio_addr_wdata <= wdata_dout;  // w fifo popped on this cycle
                end
        end

        // highest numbered device with a flag up
        always_comb begin
                sel_ack = '0;
                sel_rd  = '0;
                for (int i = 0; i < pio_bus_pkg::NUM_OF_PIO; i++) begin
                        if (pio_ack[i]) begin
                                sel_ack = $bits(sel_ack)'(i);
                        end
                        if (pio_rvalid[i]) begin
                                sel_rd = $bits(sel_rd)'(i);
                        end
                end
        end

        // flags only sampled on the owning device's enable tick
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        latch_ack       <= 1'b0;
                        latch_ack_d1    <= 1'b0;
                        latch_rvalid    <= 1'b0;
                        latch_rvalid_d1 <= 1'b0;
                end else begin
                        if (clk_div[sel_ack]) begin
                                latch_ack <= pio_ack[sel_ack];
                        end
                        if (clk_div[sel_rd]) begin
                                latch_rvalid <= pio_rvalid[sel_rd];
                        end
                        latch_ack_d1    <= latch_ack;
                        latch_rvalid_d1 <= latch_rvalid;
                end
        end

        always_ff @(posedge clk) begin
                if (clk_div[sel_rd] && pio_rvalid[sel_rd]) begin
                        latch_rdata <= pio_rdata[sel_rd];
                end
        end

        assign rdata_push = latch_rvalid && !latch_rvalid_d1;  // one push per reply
        assign wresp_push = latch_ack && !latch_ack_d1;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        time_base    <= '0;
                        current_time <= '0;
                end else begin
                        time_base    <= time_base + 1'b1;
                        current_time <= current_time + (&time_base);
                end
        end

        sfifo1f #(.payload_t(pio_bus_pkg::pio_word_t)) u_waddr_fifo (
                .clk   (clk),
                .rst_n (rst_n),
                .wr    (awvalid && awready),
                .rd    (wr_start),
                .din   (awaddr),
                .full  (waddr_full),
                .empty (waddr_empty),
                .dout  (waddr_dout)
        );

        sfifo1f #(.payload_t(pio_bus_pkg::pio_word_t)) u_wdata_fifo (
                .clk   (clk),
                .rst_n (rst_n),
                .wr    (wvalid && wready),
                .rd    (data_pend),
                .din   (wdata),
                .full  (wdata_full),
                .empty (wdata_empty),
                .dout  (wdata_dout)
        );

        sfifo1f #(.payload_t(pio_bus_pkg::pio_word_t)) u_raddr_fifo (
                .clk   (clk),
                .rst_n (rst_n),
                .wr    (arvalid && arready),
                .rd    (rd_start),
                .din   (araddr),
                .full  (raddr_full),
                .empty (raddr_empty),
                .dout  (raddr_dout)
        );

        sfifo1f #(.payload_t(pio_bus_pkg::pio_word_t)) u_rdata_fifo (
                .clk   (clk),
                .rst_n (rst_n),
                .wr    (rdata_push),
                .rd    (rdata_pop),
                .din   (latch_rdata),
                .full  (),
                .empty (rdata_empty),
                .dout  (rdata)
        );

        sfifo1f #(.payload_t(logic)) u_wresp_fifo (
                .clk   (clk),
                .rst_n (rst_n),
                .wr    (wresp_push),
                .rd    (wresp_pop),
                .din   (1'b1),
                .full  (),
                .empty (wresp_empty),
                .dout  ()
        );

endmodule

// File: design/sfifo1f.sv
`timescale 1ns/10ps

module sfifo1f #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     rst_n,
        input  logic     wr,
        input  logic     rd,
        input  payload_t din,
        output logic     full,
        output logic     empty,
        output payload_t dout
);

        logic     valid;                       // entry occupied
        payload_t data;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        valid <= 1'b0;
                end else if (wr && !valid) begin
                        valid <= 1'b1;         // write to a full fifo is dropped
                end else if (rd && valid) begin
                        valid <= 1'b0;         // read from an empty fifo is dropped
                end
        end

        always_ff @(posedge clk) begin
                if (wr && !valid) begin
                        data <= din;
                end
        end

        assign full  = valid;
        assign empty = !valid;
        assign dout  = data;

endmodule

// File: design/pio_time_pkg.sv
package pio_time_pkg;

        localparam int TIME_BASE_NBITS = 4;    // one time tick per 16 cycles
        localparam int REAL_TIME_NBITS = 32;

        typedef logic [REAL_TIME_NBITS-1:0] real_time_t;

endpackage

// File: design/pio_bus_pkg.sv
package pio_bus_pkg;

        // width of one pio address or data word
        localparam int PIO_NBITS = 16;

        typedef logic [PIO_NBITS-1:0] pio_word_t;

        // devices hanging off the pio bus
        localparam int NUM_OF_PIO = 2;

        // bit 2 selects the device and bits 1..0 the register
        localparam int DEV_SEL_BIT   = 2;
        localparam int REG_IDX_NBITS = 2;

        // one bit per device, for clk_div, pio_ack and pio_rvalid
        typedef logic [NUM_OF_PIO-1:0] pio_mask_t;

endpackage
